// ==== func_units.f ====
+incdir+hdl
hdl/fu_pkg.sv
hdl/alu_unit.sv
hdl/dmem.sv
hdl/ls_unit.sv
hdl/wb_arbiter.sv
hdl/func_units.sv
verif/fu_checker.sv
verif/tb_func_units.sv

// ==== hdl/alu_unit.sv ====
`timescale 1ns/1ps
`include "fu_cfg.svh"

module alu_unit (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               start,
  input  fu_pkg::alu_req_t   req,
  output logic               done,
  output fu_pkg::fu_result_t res
);

  // issue packet held for the execute cycle
  fu_pkg::alu_req_t req_q;

  // extra top bit carries the carry out
  logic [`GPR_SIZE:0]   sum;
  logic [`GPR_SIZE-1:0] result;
  logic                 is_add;
  logic                 is_sub;
  logic                 sign_a;
  logic                 sign_b;
  logic                 sign_r;
  fu_pkg::nzcv_t        flags;

  // done trails start by one edge
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      done <= 1'b0;
    end else begin
      done <= start;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      req_q <= req;
    end
  end

  // result from registered operands
  always_comb begin
    case (req_q.op)
      fu_pkg::ALU_OP_PLUS:  sum = {1'b0, req_q.val_a} + {1'b0, req_q.val_b};
      // a + ~b + 1 leaves the arm style no-borrow carry in the top bit
      fu_pkg::ALU_OP_MINUS: sum = {1'b0, req_q.val_a} + {1'b0, ~req_q.val_b} + 1'b1;
      fu_pkg::ALU_OP_ORN:   sum = {1'b0, req_q.val_a | ~req_q.val_b};
      fu_pkg::ALU_OP_OR:    sum = {1'b0, req_q.val_a | req_q.val_b};
      fu_pkg::ALU_OP_EOR:   sum = {1'b0, req_q.val_a ^ req_q.val_b};
      fu_pkg::ALU_OP_AND:   sum = {1'b0, req_q.val_a & req_q.val_b};
      // conditional selects take the operand the scheduler chose
      fu_pkg::ALU_OP_CSEL:  sum = {1'b0, req_q.val_b};
      fu_pkg::ALU_OP_CSINC: sum = {1'b0, req_q.val_b} + 1'b1;
      fu_pkg::ALU_OP_CSINV: sum = {1'b0, ~req_q.val_b};
      fu_pkg::ALU_OP_CSNEG: sum = {1'b0, -req_q.val_b};
      default:              sum = '0;
    endcase
  end

  assign result = sum[`GPR_SIZE-1:0];
  assign is_add = (req_q.op == fu_pkg::ALU_OP_PLUS);
  assign is_sub = (req_q.op == fu_pkg::ALU_OP_MINUS);

  // sign bits for overflow
  assign sign_a = req_q.val_a[`GPR_SIZE-1];
  assign sign_b = req_q.val_b[`GPR_SIZE-1];
  assign sign_r = result[`GPR_SIZE-1];

  always_comb begin
    if (req_q.set_nzcv) begin
      flags.n = sign_r;
      flags.z = (result == '0);
      // carry only meaningful for add and sub
      flags.c = (is_add | is_sub) & sum[`GPR_SIZE];
      // add overflows on like signs and sub on unlike signs
      flags.v = (is_add & (sign_a == sign_b) & (sign_r != sign_a)) |
                (is_sub & (sign_a != sign_b) & (sign_r != sign_a));
    end else begin
      // untouched flags pass back to the rob
      flags = req_q.nzcv;
    end
  end

  assign res = '{
    dst_rob_index: req_q.dst_rob_index,
    value:         result,
    set_nzcv:      req_q.set_nzcv,
    nzcv:          flags
  };

  // each issue completes next cycle with its own rob index
  issue_completes_next: assert property (
    @(posedge clk) disable iff (!arst_n)
    start |=> (done && res.dst_rob_index == $past(req.dst_rob_index))
  ) else $error("alu issue did not complete on the next cycle");

  // subtract carry must agree with an unsigned compare of the operands
  sub_carry_is_no_borrow: assert property (
    @(posedge clk) disable iff (!arst_n)
    (done && is_sub) |-> (sum[`GPR_SIZE] == (req_q.val_a >= req_q.val_b))
  ) else $error("alu subtract carry disagrees with the unsigned compare");

endmodule

// ==== hdl/dmem.sv ====
`timescale 1ns/1ps
`include "fu_cfg.svh"

module dmem (
  input  logic                           clk,
  input  logic [$clog2(`DMEM_BYTES)-1:0] addr,
  input  logic                           wr_en,
  input  logic [`GPR_SIZE-1:0]           wdata,
  output logic [`GPR_SIZE-1:0]           rdata
);

  localparam int addr_w         = $clog2(`DMEM_BYTES);
  localparam int bytes_per_word = `GPR_SIZE / 8;

  logic [7:0]        mem [`DMEM_BYTES];
  logic [addr_w-1:0] byte_addr [bytes_per_word];

  // memory starts out zeroed
  initial begin
    for (int i = 0; i < `DMEM_BYTES; i++) begin
      mem[i] = 8'h00;
    end
  end

  // lane addresses, wrap at the top of memory
  always_comb begin
    for (int i = 0; i < bytes_per_word; i++) begin
      byte_addr[i] = addr + addr_w'(i);
    end
  end

  // little-endian write, lane 0 at the lowest address
  always @(posedge clk) begin
    if (wr_en) begin
      for (int i = 0; i < bytes_per_word; i++) begin
        mem[byte_addr[i]] <= wdata[8*i +: 8];
      end
    end
  end

  // registered read
  always_ff @(posedge clk) begin
    if (!wr_en) begin
      for (int i = 0; i < bytes_per_word; i++) begin
        rdata[8*i +: 8] <= mem[byte_addr[i]];
      end
    end
  end

endmodule

// ==== hdl/fu_cfg.svh ====
`ifndef FU_CFG_SVH
`define FU_CFG_SVH

// operand and result width
`define GPR_SIZE 64

// reorder buffer index width
`define ROB_IDX_SIZE 4

// data memory size in bytes
// addresses wrap modulo this size
`define DMEM_BYTES 256

`endif

// ==== hdl/fu_pkg.sv ====
`include "fu_cfg.svh"

package fu_pkg;

  // alu opcodes as issued by the reservation stations
  // codes 10 to 15 are unused and give a zero result
  typedef enum logic [3:0] {
    ALU_OP_PLUS  = 4'd0,
    ALU_OP_MINUS = 4'd1,
    ALU_OP_ORN   = 4'd2,
    ALU_OP_OR    = 4'd3,
    ALU_OP_EOR   = 4'd4,
    ALU_OP_AND   = 4'd5,
    ALU_OP_CSEL  = 4'd6,
    ALU_OP_CSINC = 4'd7,
    ALU_OP_CSINV = 4'd8,
    ALU_OP_CSNEG = 4'd9
  } alu_op_t;

  // condition flags, msb first as in the pstate layout
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } nzcv_t;

  // alu issue packet
  typedef struct packed {
    alu_op_t                   op;
    logic [`GPR_SIZE-1:0]      val_a;
    logic [`GPR_SIZE-1:0]      val_b;
    logic [`ROB_IDX_SIZE-1:0]  dst_rob_index;
    logic                      set_nzcv;
    nzcv_t                     nzcv;
  } alu_req_t;

  // load/store issue packet, address is base plus offset
  typedef struct packed {
    logic                      is_store;
    logic [`GPR_SIZE-1:0]      base;
    logic [`GPR_SIZE-1:0]      offset;
    logic [`GPR_SIZE-1:0]      store_val;
    logic [`ROB_IDX_SIZE-1:0]  dst_rob_index;
  } ls_req_t;

  // completion packet seen by the reorder buffer
  typedef struct packed {
    logic [`ROB_IDX_SIZE-1:0]  dst_rob_index;
    logic [`GPR_SIZE-1:0]      value;
    logic                      set_nzcv;
    nzcv_t                     nzcv;
  } fu_result_t;

endpackage

// ==== hdl/func_units.sv ====
`timescale 1ns/1ps

module func_units (
  input  logic               clk,
  input  logic               arst_n,
  // reservation station side
  input  logic               alu_start,
  input  fu_pkg::alu_req_t   alu_req,
  input  logic               ls_start,
  input  fu_pkg::ls_req_t    ls_req,
  output logic               alu_ready,
  output logic               ls_ready,
  // reorder buffer side
  output logic               rob_done,
  output fu_pkg::fu_result_t rob_result
);

  logic               alu_done;
  fu_pkg::fu_result_t alu_res;
  logic               ls_valid;
  fu_pkg::fu_result_t ls_res;
  logic               ls_grant;

  // alu is fully pipelined, ready once out of reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      alu_ready <= 1'b0;
    end else begin
      alu_ready <= 1'b1;
    end
  end

  alu_unit alu_unit_i (
    .clk    (clk),
    .arst_n (arst_n),
    .start  (alu_start),
    .req    (alu_req),
    .done   (alu_done),
    .res    (alu_res)
  );

  ls_unit ls_unit_i (
    .clk    (clk),
    .arst_n (arst_n),
    .start  (ls_start),
    .req    (ls_req),
    .ready  (ls_ready),
    .valid  (ls_valid),
    .res    (ls_res),
    .grant  (ls_grant)
  );

  // single result port shared by both units
  wb_arbiter wb_arbiter_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .alu_done   (alu_done),
    .alu_res    (alu_res),
    .ls_valid   (ls_valid),
    .ls_res     (ls_res),
    .ls_grant   (ls_grant),
    .rob_done   (rob_done),
    .rob_result (rob_result)
  );

endmodule

// ==== hdl/ls_unit.sv ====
`timescale 1ns/1ps
`include "fu_cfg.svh"

module ls_unit (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               start,
  input  fu_pkg::ls_req_t    req,
  output logic               ready,
  output logic               valid,
  output fu_pkg::fu_result_t res,
  input  logic               grant
);

  localparam int addr_w = $clog2(`DMEM_BYTES);

  // idle -> access (memory driven) -> hold (capture, then wait for grant)
  typedef enum logic [1:0] {
    LS_IDLE,
    LS_ACCESS,
    LS_HOLD
  } ls_state_t;

  ls_state_t state;

  // request fields kept for the whole operation
  logic [addr_w-1:0]        addr_q;
  logic                     is_store_q;
  logic [`GPR_SIZE-1:0]     store_val_q;
  logic [`ROB_IDX_SIZE-1:0] rob_index_q;

  logic                     wr_en;
  logic [`GPR_SIZE-1:0]     rdata;
  fu_pkg::fu_result_t       res_d;
  fu_pkg::fu_result_t       res_q;

  // sequencer, one op in flight
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= LS_IDLE;
      ready <= 1'b1;
      valid <= 1'b0;
    end else begin
      case (state)
        LS_IDLE: begin
          if (start) begin
            state <= LS_ACCESS;
            ready <= 1'b0;
          end
        end
        LS_ACCESS: begin
          // memory op happens on this edge
          state <= LS_HOLD;
        end
        LS_HOLD: begin
          if (!valid) begin
            valid <= 1'b1;
          end else if (grant) begin
            // result leaves at the end of the granted cycle
            valid <= 1'b0;
            ready <= 1'b1;
            state <= LS_IDLE;
          end
        end
        default: begin
          state <= LS_IDLE;
        end
      endcase
    end
  end

  // address generation and request capture at issue
  always_ff @(posedge clk) begin
    if (state == LS_IDLE && start) begin
      addr_q      <= addr_w'(req.base + req.offset);
      is_store_q  <= req.is_store;
      store_val_q <= req.store_val;
      rob_index_q <= req.dst_rob_index;
    end
  end

  // hold register, filled once read data has settled
  always_ff @(posedge clk) begin
    if (state == LS_HOLD && !valid) begin
      res_q <= res_d;
    end
  end

  // store reports its own data
  assign res_d = '{
    dst_rob_index: rob_index_q,
    value:         is_store_q ? store_val_q : rdata,
    set_nzcv:      1'b0,
    nzcv:          '0
  };

  assign res   = res_q;
  assign wr_en = (state == LS_ACCESS) & is_store_q;

  dmem dmem_i (
    .clk   (clk),
    .addr  (addr_q),
    .wr_en (wr_en),
    .wdata (store_val_q),
    .rdata (rdata)
  );

  // scheduler must wait for ready
  start_only_when_ready: assert property (
    @(posedge clk) disable iff (!arst_n)
    start |-> ready
  ) else $error("ls start issued while unit busy");

  // arbiter may only grant a held result
  grant_only_when_valid: assert property (
    @(posedge clk) disable iff (!arst_n)
    grant |-> valid
  ) else $error("ls grant without a valid result");

endmodule

// ==== hdl/wb_arbiter.sv ====
`timescale 1ns/1ps

module wb_arbiter (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               alu_done,
  input  fu_pkg::fu_result_t alu_res,
  input  logic               ls_valid,
  input  fu_pkg::fu_result_t ls_res,
  output logic               ls_grant,
  output logic               rob_done,
  output fu_pkg::fu_result_t rob_result
);

  // longest tolerated push-back of a load/store result
  localparam int max_wait = 16;
  // two spare bits so the counter can pass the limit
  localparam int wait_w   = $clog2(max_wait) + 2;

  logic [wait_w-1:0] wait_cnt;

  // alu always wins the single rob port
  assign ls_grant = ls_valid & ~alu_done;
  assign rob_done = alu_done | ls_grant;

  always_comb begin
    if (alu_done) begin
      rob_result = alu_res;
    end else begin
      rob_result = ls_res;
    end
  end

  // cycles a finished ls result has been blocked
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wait_cnt <= '0;
    end else if (ls_valid && !ls_grant) begin
      // saturate
      if (wait_cnt != '1) begin
        wait_cnt <= wait_cnt + 1'b1;
      end
    end else begin
      wait_cnt <= '0;
    end
  end

  // starvation guard against a long alu burst
  ls_not_starved: assert property (
    @(posedge clk) disable iff (!arst_n)
    wait_cnt <= wait_w'(max_wait)
  ) else $error("ls result blocked for more than %0d cycles", max_wait);

endmodule

// ==== verif/fu_checker.sv ====
`timescale 1ns/1ps
`include "fu_cfg.svh"

module fu_checker (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               alu_start,
  input  fu_pkg::alu_req_t   alu_req,
  input  logic               ls_start,
  input  fu_pkg::ls_req_t    ls_req,
  input  logic               alu_ready,
  input  logic               ls_ready,
  input  logic               rob_done,
  input  fu_pkg::fu_result_t rob_result,
  // expected completion from the stimulus table, alongside a start
  input  logic               tbl_valid,
  input  fu_pkg::fu_result_t tbl_exp,
  input  logic               end_check,
  output int                 mismatch_cnt,
  output int                 other_cnt
);

  localparam int rob_depth = 1 << `ROB_IDX_SIZE;

  logic [7:0]               model_mem [`DMEM_BYTES];
  fu_pkg::fu_result_t       exp_tab [rob_depth];
  logic                     pending [rob_depth];
  logic                     alu_start_q;
  logic [`ROB_IDX_SIZE-1:0] alu_idx_q;
  logic                     seen_start;
  int                       live_cycles;
  fu_pkg::fu_result_t       ls_exp;
  int                       mism_total = 0;
  int                       other_total = 0;

  assign mismatch_cnt = mism_total;
  assign other_cnt    = other_total;

  // reference alu, flags from the architectural rules
  function automatic fu_pkg::fu_result_t alu_expect(input fu_pkg::alu_req_t r);
    fu_pkg::fu_result_t   e;
    logic [`GPR_SIZE:0]   wide;
    logic [`GPR_SIZE:0]   sext;
    logic [`GPR_SIZE-1:0] a;
    logic [`GPR_SIZE-1:0] b;
    a = r.val_a;
    b = r.val_b;
    wide = '0;
    // sign-extended by one bit, overflow when the top two bits differ
    sext = '0;
    case (r.op)
      fu_pkg::ALU_OP_PLUS: begin
        wide = {1'b0, a} + {1'b0, b};
        sext = {a[`GPR_SIZE-1], a} + {b[`GPR_SIZE-1], b};
      end
      fu_pkg::ALU_OP_MINUS: begin
        wide = {(a >= b), a - b};
        sext = {a[`GPR_SIZE-1], a} - {b[`GPR_SIZE-1], b};
      end
      fu_pkg::ALU_OP_ORN:   wide[`GPR_SIZE-1:0] = a | ~b;
      fu_pkg::ALU_OP_OR:    wide[`GPR_SIZE-1:0] = a | b;
      fu_pkg::ALU_OP_EOR:   wide[`GPR_SIZE-1:0] = a ^ b;
      fu_pkg::ALU_OP_AND:   wide[`GPR_SIZE-1:0] = a & b;
      fu_pkg::ALU_OP_CSEL:  wide[`GPR_SIZE-1:0] = b;
      fu_pkg::ALU_OP_CSINC: wide[`GPR_SIZE-1:0] = b + 1;
      fu_pkg::ALU_OP_CSINV: wide[`GPR_SIZE-1:0] = ~b;
      fu_pkg::ALU_OP_CSNEG: wide[`GPR_SIZE-1:0] = 0 - b;
      default:              wide = '0;
    endcase
    e.dst_rob_index = r.dst_rob_index;
    e.value         = wide[`GPR_SIZE-1:0];
    e.set_nzcv      = r.set_nzcv;
    e.nzcv          = r.nzcv;
    if (r.set_nzcv) begin
      e.nzcv.n = e.value[`GPR_SIZE-1];
      e.nzcv.z = (e.value == 0);
      e.nzcv.c = wide[`GPR_SIZE];
      e.nzcv.v = sext[`GPR_SIZE] ^ sext[`GPR_SIZE-1];
    end
    return e;
  endfunction

  // model memory updated in issue order, one ls op in flight
  task automatic ls_expect(input fu_pkg::ls_req_t r, output fu_pkg::fu_result_t e);
    logic [`GPR_SIZE-1:0] sum;
    int                   addr;
    sum  = r.base + r.offset;
    addr = int'(sum % `DMEM_BYTES);
    e = '0;
    e.dst_rob_index = r.dst_rob_index;
    for (int i = 0; i < `GPR_SIZE / 8; i++) begin
      if (r.is_store) begin
        model_mem[(addr + i) % `DMEM_BYTES] = r.store_val[8*i +: 8];
      end else begin
        e.value[8*i +: 8] = model_mem[(addr + i) % `DMEM_BYTES];
      end
    end
    if (r.is_store) begin
      e.value = r.store_val;
    end
  endtask

  task automatic record_issue(input fu_pkg::fu_result_t e);
    if (pending[e.dst_rob_index]) begin
      $display("rob index %0d issued again while still pending", e.dst_rob_index);
      other_total++;
    end
    if (tbl_valid && tbl_exp !== e) begin
      $display("stimulus table entry for rob index %0d disagrees with the reference model",
               e.dst_rob_index);
      other_total++;
    end
    exp_tab[e.dst_rob_index] = e;
    pending[e.dst_rob_index] = 1'b1;
  endtask

  task automatic compare_result(input fu_pkg::fu_result_t got);
    fu_pkg::fu_result_t e;
    e = exp_tab[got.dst_rob_index];
    if (got.value !== e.value) begin
      $display("Mismatch rob_result.value rob %0d: got %h expected %h",
               got.dst_rob_index, got.value, e.value);
      mism_total++;
    end
    if (got.set_nzcv !== e.set_nzcv) begin
      $display("Mismatch rob_result.set_nzcv rob %0d: got %h expected %h",
               got.dst_rob_index, got.set_nzcv, e.set_nzcv);
      mism_total++;
    end
    if (got.nzcv !== e.nzcv) begin
      $display("Mismatch rob_result.nzcv rob %0d: got %h expected %h",
               got.dst_rob_index, got.nzcv, e.nzcv);
      mism_total++;
    end
  endtask

  always @(posedge clk) begin
    if (!arst_n) begin
      for (int i = 0; i < `DMEM_BYTES; i++) begin
        model_mem[i] = 8'h00;
      end
      for (int i = 0; i < rob_depth; i++) begin
        pending[i] = 1'b0;
      end
      alu_start_q = 1'b0;
      seen_start  = 1'b0;
      live_cycles = 0;
    end else begin
      live_cycles++;
      // quiet window after reset
      if (!seen_start && !alu_start && !ls_start) begin
        if (rob_done) begin
          $display("rob_done went high before any start");
          other_total++;
        end
        if (!ls_ready || (live_cycles > 1 && !alu_ready)) begin
          $display("a ready output was low after reset");
          other_total++;
        end
      end
      // alu latency is exactly one cycle
      if (alu_start_q && !(rob_done && rob_result.dst_rob_index == alu_idx_q)) begin
        $display("alu result for rob index %0d did not appear one cycle after its start",
                 alu_idx_q);
        other_total++;
      end
      // completions before new issues at the same edge
      if (rob_done) begin
        if (!pending[rob_result.dst_rob_index]) begin
          $display("rob_done for rob index %0d with no pending operation",
                   rob_result.dst_rob_index);
          other_total++;
        end else begin
          compare_result(rob_result);
          pending[rob_result.dst_rob_index] = 1'b0;
        end
      end
      if (alu_start) begin
        record_issue(alu_expect(alu_req));
      end
      if (ls_start) begin
        ls_expect(ls_req, ls_exp);
        record_issue(ls_exp);
      end
      alu_start_q = alu_start;
      alu_idx_q   = alu_req.dst_rob_index;
      seen_start  = seen_start | alu_start | ls_start;
      if (end_check) begin
        for (int i = 0; i < rob_depth; i++) begin
          if (pending[i]) begin
            $display("rob index %0d never completed", i);
            other_total++;
          end
        end
        if (!ls_ready) begin
          $display("ls_ready did not return high at the end of the test");
          other_total++;
        end
      end
    end
  end

endmodule

// ==== verif/tb_func_units.sv ====
`timescale 1ns/1ps
`include "fu_cfg.svh"

module tb_func_units;

  localparam int n_rows    = 24;
  localparam int n_random  = 16;
  localparam int wd_cycles = (n_rows + n_random) * 8 + 100;

  localparam logic [`GPR_SIZE-1:0] all_ones = '1;
  localparam logic [`GPR_SIZE-1:0] top_bit  = {1'b1, {(`GPR_SIZE-1){1'b0}}};
  localparam logic [`GPR_SIZE-1:0] max_pos  = ~top_bit;

  // one issue with its expected completion
  typedef struct packed {
    logic                     is_ls;
    logic                     is_store;
    logic [3:0]               op;
    logic [`GPR_SIZE-1:0]     a;
    logic [`GPR_SIZE-1:0]     b;
    logic [`GPR_SIZE-1:0]     st;
    logic                     set_nzcv;
    logic [3:0]               nzcv;
    logic [3:0]               gap;
    logic [`ROB_IDX_SIZE-1:0] rob;
    logic                     has_exp;
    logic [`GPR_SIZE-1:0]     exp_value;
    logic [3:0]               exp_nzcv;
  } row_t;

  logic               clk;
  logic               arst_n;
  logic               alu_start;
  fu_pkg::alu_req_t   alu_req;
  logic               ls_start;
  fu_pkg::ls_req_t    ls_req;
  logic               alu_ready;
  logic               ls_ready;
  logic               rob_done;
  fu_pkg::fu_result_t rob_result;
  logic               tbl_valid;
  fu_pkg::fu_result_t tbl_exp;
  logic               end_check;
  int                 mismatch_cnt;
  int                 other_cnt;
  row_t               rows[$];

  func_units func_units_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .alu_start  (alu_start),
    .alu_req    (alu_req),
    .ls_start   (ls_start),
    .ls_req     (ls_req),
    .alu_ready  (alu_ready),
    .ls_ready   (ls_ready),
    .rob_done   (rob_done),
    .rob_result (rob_result)
  );

  fu_checker fu_checker_i (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic alu_entry(input logic [3:0] op, input logic [`GPR_SIZE-1:0] a, b,
                           input logic set, input logic [3:0] fin, input int gap,
                           input logic [`GPR_SIZE-1:0] ev, input logic [3:0] ef);
    row_t r;
    r = '{op: op, a: a, b: b, set_nzcv: set, nzcv: fin, gap: 4'(gap), has_exp: 1'b1,
          exp_value: ev, exp_nzcv: ef, default: '0};
    r.rob = `ROB_IDX_SIZE'(rows.size());
    rows.push_back(r);
  endtask

  // load/store row without flags
  task automatic mem_entry(input logic st, input logic [`GPR_SIZE-1:0] base, offset, val, ev);
    row_t r;
    r = '{is_ls: 1'b1, is_store: st, a: base, b: offset, st: val, has_exp: 1'b1,
          exp_value: ev, default: '0};
    r.rob = `ROB_IDX_SIZE'(rows.size());
    rows.push_back(r);
  endtask

  task automatic build_table();
    // edge operands with carry and overflow
    alu_entry(fu_pkg::ALU_OP_PLUS, all_ones, 64'd1, 1, 4'b0000, 0, 64'd0, 4'b0110);
    alu_entry(fu_pkg::ALU_OP_PLUS, top_bit, top_bit, 1, 4'b0000, 0, 64'd0, 4'b0111);
    alu_entry(fu_pkg::ALU_OP_PLUS, max_pos, 64'd1, 1, 4'b0000, 0, top_bit, 4'b1001);
    alu_entry(fu_pkg::ALU_OP_MINUS, 64'd5, 64'd5, 1, 4'b0000, 0, 64'd0, 4'b0110);
    alu_entry(fu_pkg::ALU_OP_MINUS, 64'd0, 64'd1, 1, 4'b0000, 1, all_ones, 4'b1000);
    alu_entry(fu_pkg::ALU_OP_MINUS, top_bit, 64'd1, 1, 4'b0000, 0, max_pos, 4'b0011);
    alu_entry(fu_pkg::ALU_OP_ORN, 64'd0, all_ones, 1, 4'b0000, 0, 64'd0, 4'b0100);
    alu_entry(fu_pkg::ALU_OP_OR, top_bit, 64'd1, 0, 4'b1010, 0, top_bit | 64'd1, 4'b1010);
    alu_entry(fu_pkg::ALU_OP_EOR, all_ones, 64'h0123_4567_89ab_cdef, 1, 4'b0000, 0,
              64'hfedc_ba98_7654_3210, 4'b1000);
    alu_entry(fu_pkg::ALU_OP_AND, all_ones, top_bit, 1, 4'b0000, 0, top_bit, 4'b1000);
    alu_entry(fu_pkg::ALU_OP_CSEL, 64'd1, all_ones, 0, 4'b0101, 0, all_ones, 4'b0101);
    alu_entry(fu_pkg::ALU_OP_CSINC, 64'd0, all_ones, 1, 4'b0000, 0, 64'd0, 4'b0100);
    alu_entry(fu_pkg::ALU_OP_CSINV, 64'd0, 64'd0, 0, 4'b1111, 0, all_ones, 4'b1111);
    alu_entry(fu_pkg::ALU_OP_CSNEG, 64'd0, 64'd1, 1, 4'b0000, 0, all_ones, 4'b1000);
    // unused opcode
    alu_entry(4'd12, all_ones, all_ones, 1, 4'b0000, 2, 64'd0, 4'b0100);
    // store then load back, then wrap at the top of memory
    mem_entry(1'b1, 64'd8, 64'd0, 64'h1122_3344_5566_7788, 64'h1122_3344_5566_7788);
    mem_entry(1'b0, 64'd4, 64'd4, 64'd0, 64'h1122_3344_5566_7788);
    mem_entry(1'b1, 64'd250, 64'd2, 64'h0807_0605_0403_0201, 64'h0807_0605_0403_0201);
    mem_entry(1'b0, all_ones, 64'd253, 64'd0, 64'h0807_0605_0403_0201);
    mem_entry(1'b0, 64'd0, 64'd254, 64'd0, 64'h0000_0807_0605_0403);
    mem_entry(1'b0, 64'd12, 64'd0, 64'd0, 64'h0000_0000_1122_3344);
    // alu burst pushes back the load above
    alu_entry(fu_pkg::ALU_OP_PLUS, 64'd1, 64'd2, 1, 4'b0000, 0, 64'd3, 4'b0000);
    alu_entry(fu_pkg::ALU_OP_MINUS, 64'd1, 64'd2, 1, 4'b0000, 0, all_ones, 4'b1000);
    alu_entry(fu_pkg::ALU_OP_AND, 64'h00ff_00ff_00ff_00ff, 64'h0f0f_0f0f_0f0f_0f0f, 0,
              4'b0011, 0, 64'h000f_000f_000f_000f, 4'b0011);
  endtask

  task automatic drive_row(input row_t r);
    alu_start <= 1'b0;
    ls_start  <= 1'b0;
    tbl_valid <= r.has_exp;
    tbl_exp   <= '{dst_rob_index: r.rob, value: r.exp_value, set_nzcv: r.set_nzcv,
                   nzcv: r.exp_nzcv};
    if (r.is_ls) begin
      ls_start <= 1'b1;
      ls_req   <= '{is_store: r.is_store, base: r.a, offset: r.b, store_val: r.st,
                    dst_rob_index: r.rob};
    end else begin
      alu_start <= 1'b1;
      alu_req   <= '{op: fu_pkg::alu_op_t'(r.op), val_a: r.a, val_b: r.b,
                     dst_rob_index: r.rob, set_nzcv: r.set_nzcv, nzcv: r.nzcv};
    end
  endtask

  // called and returning on a rising edge
  task automatic apply_row(input row_t r);
    if (r.is_ls) begin
      // ready has settled by the falling edge
      @(negedge clk);
      while (!ls_ready) begin
        @(negedge clk);
      end
      @(posedge clk);
    end
    drive_row(r);
    @(posedge clk);
    alu_start <= 1'b0;
    ls_start  <= 1'b0;
    tbl_valid <= 1'b0;
    repeat (r.gap) @(posedge clk);
  endtask

  // random alu row with undefined opcodes included
  task automatic make_random(inout logic [31:0] rng, input int idx, output row_t r);
    r = '0;
    rng = xorshift32(rng);
    r.op = rng[3:0];
    r.set_nzcv = rng[4];
    r.nzcv = rng[8:5];
    r.gap = {3'b000, rng[9]};
    for (int k = 0; k < 4; k++) begin
      rng = xorshift32(rng);
      if (k < 2) begin
        r.a = {r.a[31:0], rng};
      end else begin
        r.b = {r.b[31:0], rng};
      end
    end
    r.rob = `ROB_IDX_SIZE'(idx);
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    repeat (wd_cycles) @(posedge clk);
    $display("timeout: test did not finish within %0d cycles", wd_cycles);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    logic [31:0] rng;
    row_t        r;
    arst_n    = 1'b0;
    alu_start = 1'b0;
    alu_req   = '0;
    ls_start  = 1'b0;
    ls_req    = '0;
    tbl_valid = 1'b0;
    tbl_exp   = '0;
    end_check = 1'b0;
    rng       = 32'hb66b_2d95;
    build_table();
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    // idle window for the post-reset checks
    repeat (4) @(posedge clk);
    foreach (rows[i]) begin
      apply_row(rows[i]);
    end
    while (!ls_ready) begin
      @(posedge clk);
    end
    for (int i = 0; i < n_random; i++) begin
      make_random(rng, n_rows + i, r);
      apply_row(r);
    end
    // drain before the leftover check
    repeat (4) @(posedge clk);
    end_check <= 1'b1;
    @(posedge clk);
    end_check <= 1'b0;
    @(negedge clk);
    $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
